// ==== run.sh ====
#!/usr/bin/env bash
# build and run the load/store block testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module tb_top -o tb_sim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit "$status"
fi

exit 0

// ==== src/byte_ram.sv ====
/* byte-wide RAM, combinational read and clocked write */
`timescale 1ns/1ps

module byte_ram import ls_types_pkg::*, ls_map_pkg::*; (
    input  logic           ctl,
    input  logic [asz-1:0] mem_addr,      // upper bits ignored
    input  logic [7:0]     mem_wdata,
    input  logic           mem_we,
    output logic [7:0]     mem_rdata
);

    logic [7:0]        mem [1 << ram_aw];
    logic [ram_aw-1:0] idx;               // wrapped address

    assign idx       = mem_addr[ram_aw-1:0];
    assign mem_rdata = mem[idx];          // same-cycle read

    // start from an all-zero array
    initial begin
        for (int i = 0; i < (1 << ram_aw); i++) begin
            mem[i] = 8'h00;
        end
    end

    always @(posedge ctl) begin
        if (mem_we) begin
            mem[idx] <= mem_wdata;
        end
    end

endmodule

// ==== src/ls_map_pkg.sv ====
/* memory map of the load/store block
   RAM size and the reset values of the buffer pointers */
package ls_map_pkg;

    localparam int ram_aw = 12;                  // 4 KB of byte RAM

    // input buffer (TIB), filled by stores and drained by get
    localparam int unsigned tib_base  = 'h0C00;

    // output buffer, filled by put
    localparam int unsigned obuf_base = 'h0E00;

endpackage

// ==== src/ls_phase_counter.sv ====
/* phase counter, the timer of a running command */
`timescale 1ns/1ps

module ls_phase_counter import ls_types_pkg::*; (
    input  logic               ctl,
    input  logic               arst_n,
    input  logic               phase_clear,  // command accepted
    input  logic               phase_step,   // advance one phase
    output logic [phase_w-1:0] phase
);

    always_ff @(posedge ctl or negedge arst_n) begin
        if (!arst_n) begin
            phase <= '0;
        end else if (phase_clear) begin      // clear wins over step
            phase <= '0;
        end else if (phase_step) begin
            phase <= phase + 1'b1;
        end
    end

endmodule

// ==== src/ls_sequencer.sv ====
/* load/store command sequencer
   accepts one command, holds its operands and steps phases to done */
`timescale 1ns/1ps

module ls_sequencer import ls_types_pkg::*; (
    input  logic               ctl,
    input  logic               arst_n,
    input  logic               start,       // one-cycle command strobe
    input  ls_op_t             op,
    input  logic [dsz-1:0]     tos_in,
    input  logic [dsz-1:0]     nos_in,
    input  logic [phase_w-1:0] phase,
    input  logic [dsz-1:0]     tos_next,    // merged TOS from the unit
    input  logic               tos_load,
    output logic               busy,
    output logic               done,
    output logic               running,
    output ls_op_t             cur_op,
    output logic [dsz-1:0]     tos,
    output logic [dsz-1:0]     nos,
    output logic               phase_clear,
    output logic               phase_step
);

    typedef enum logic [1:0] {
        s_idle,
        s_run,
        s_finish
    } state_t;

    state_t state, state_n;
    logic   accept;                         // start taken this edge
    logic   last;                           // final phase of cur_op

    assign running     = (state == s_run);
    assign busy        = running;           // drops as done rises
    assign done        = (state == s_finish);
    assign accept      = start && !busy;    // strobe ignored while busy
    assign last        = (phase == op_last_phase(cur_op));
    assign phase_clear = accept;
    assign phase_step  = running && !last;  // hold phase at last

    always_comb begin
        state_n = state;
        case (state)
            s_idle:   if (accept) state_n = s_run;
            s_run:    if (last) state_n = s_finish;
            s_finish: state_n = accept ? s_run : s_idle; // back-to-back ok
            default:  state_n = s_idle;
        endcase
    end

    always_ff @(posedge ctl or negedge arst_n) begin
        if (!arst_n) begin
            state <= s_idle;
        end else begin
            state <= state_n;
        end
    end

    // command operands and the TOS register
    always_ff @(posedge ctl) begin
        if (accept) begin
            cur_op <= op;
            nos    <= nos_in;
        end
        if (accept) begin
            tos <= tos_in;
        end else if (tos_load) begin        // only while running
            tos <= tos_next;
        end
    end

endmodule

// ==== src/ls_top.sv ====
/* load/store block top level
   sequencer, phase counter, datapath and byte RAM */
`timescale 1ns/1ps

module ls_top import ls_types_pkg::*; (
    input  logic           ctl,
    input  logic           arst_n,
    input  logic           start,
    input  ls_op_t         op,
    input  logic [dsz-1:0] tos_in,       // address for loads, data for stores
    input  logic [dsz-1:0] nos_in,       // store address
    output logic           busy,
    output logic           done,
    output logic [dsz-1:0] tos_out
);

    logic               running;
    ls_op_t             cur_op;
    logic [dsz-1:0]     nos;
    logic               phase_clear;
    logic               phase_step;
    logic [phase_w-1:0] phase;
    logic [dsz-1:0]     tos_next;        // unit to sequencer TOS uplink
    logic               tos_load;
    logic [asz-1:0]     mem_addr;
    logic [7:0]         mem_wdata;
    logic [7:0]         mem_rdata;
    logic               mem_we;

    ls_sequencer u_seq (
        .ctl         (ctl),
        .arst_n      (arst_n),
        .start       (start),
        .op          (op),
        .tos_in      (tos_in),
        .nos_in      (nos_in),
        .phase       (phase),
        .tos_next    (tos_next),
        .tos_load    (tos_load),
        .busy        (busy),
        .done        (done),
        .running     (running),
        .cur_op      (cur_op),
        .tos         (tos_out),
        .nos         (nos),
        .phase_clear (phase_clear),
        .phase_step  (phase_step)
    );

    ls_phase_counter u_phase (
        .ctl         (ctl),
        .arst_n      (arst_n),
        .phase_clear (phase_clear),
        .phase_step  (phase_step),
        .phase       (phase)
    );

    ls_unit u_ls (
        .ctl       (ctl),
        .arst_n    (arst_n),
        .running   (running),
        .op        (cur_op),
        .phase     (phase),
        .tos       (tos_out),
        .nos       (nos),
        .mem_rdata (mem_rdata),
        .tos_next  (tos_next),
        .tos_load  (tos_load),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we)
    );

    byte_ram u_ram (
        .ctl       (ctl),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_rdata (mem_rdata)
    );

endmodule

// ==== src/ls_types_pkg.sv ====
/* load/store core types
   opcode encoding, datapath widths and the last phase of each command */
package ls_types_pkg;

    localparam int dsz     = 32;             // stack word width
    localparam int asz     = 16;             // byte address width
    localparam int phase_w = 3;              // phase counter width

    typedef enum logic [2:0] {
        iaload  = 3'd0,                      // 32-bit load
        saload  = 3'd1,                      // 16-bit load
        baload  = 3'd2,                      // 8-bit load
        iastore = 3'd3,
        sastore = 3'd4,
        bastore = 3'd5,
        get     = 3'd6,                      // next byte of input buffer
        put     = 3'd7                       // next byte of output buffer
    } ls_op_t;

    // one byte per phase after the address phase
    function automatic logic [phase_w-1:0] op_last_phase(ls_op_t op);
        case (op)
            iaload, iastore: return phase_w'(4);
            saload, sastore: return phase_w'(2);
            default:         return phase_w'(1); // byte ops, get, put
        endcase
    endfunction

endpackage

// ==== src/ls_unit.sv ====
/* load/store datapath
   address register, byte select, big-endian TOS merge and buffer pointers */
`timescale 1ns/1ps

module ls_unit import ls_types_pkg::*, ls_map_pkg::*; (
    input  logic               ctl,
    input  logic               arst_n,
    input  logic               running,     // registers move only here
    input  ls_op_t             op,
    input  logic [phase_w-1:0] phase,
    input  logic [dsz-1:0]     tos,
    input  logic [dsz-1:0]     nos,
    input  logic [7:0]         mem_rdata,
    output logic [dsz-1:0]     tos_next,
    output logic               tos_load,
    output logic [asz-1:0]     mem_addr,
    output logic [7:0]         mem_wdata,
    output logic               mem_we
);

    // registers and their next values
    logic [asz-1:0] addr_r, addr_n;         // memory address
    logic           addr_x;
    logic [1:0]     dsel, dsel_n;           // store byte, 0 is msb
    logic           dsel_x;
    logic [asz-1:0] ibuf, obuf;             // buffer pointers
    logic           ibuf_x, obuf_x;

    // wires
    logic [asz-1:0]  base;                  // phase-0 address source
    logic [1:0]      first_sel;             // phase-0 byte select
    logic            last;
    logic [3:0][7:0] tos_bytes;             // [3] is msb
    logic [dsz-1:0]  d2t;                   // first byte, zero-extended
    logic [dsz-1:0]  t_d;                   // byte shifted in at low end

    assign tos_bytes = tos;
    assign d2t       = {{(dsz-8){1'b0}}, mem_rdata};
    assign t_d       = {tos[dsz-9:0], mem_rdata};
    assign last      = (phase == op_last_phase(op));
    assign mem_addr  = addr_r;              // no pc on this bus
    assign mem_wdata = tos_bytes[~dsel];    // ~dsel == 3 - dsel, big-endian

    // 32-bit stores start at msb, 16-bit at byte 2, the rest at lsb
    assign first_sel = (op == iastore) ? 2'd0 :
                       (op == sastore) ? 2'd2 : 2'd3;

    always_comb begin
        case (op)
            iaload, saload, baload: base = tos[asz-1:0];
            get:                    base = ibuf;
            put:                    base = obuf;
            default:                base = nos[asz-1:0]; // stores
        endcase
    end

    // phase table, phase 0 sets up the address and later phases move bytes
    always_comb begin
        tos_next = d2t;
        tos_load = 1'b0;
        addr_n   = addr_r + 1'b1;           // step to next byte
        addr_x   = 1'b0;
        dsel_n   = dsel + 1'b1;
        dsel_x   = 1'b0;
        mem_we   = 1'b0;
        ibuf_x   = 1'b0;
        obuf_x   = 1'b0;
        if (running) begin
            if (phase == '0) begin
                addr_n = base;
                addr_x = 1'b1;
                dsel_n = first_sel;
                dsel_x = 1'b1;
            end else begin
                addr_x = !last;             // no step after final byte
                case (op)
                    iaload, saload, baload, get: begin
                        tos_next = (phase == phase_w'(1)) ? d2t : t_d;
                        tos_load = 1'b1;
                    end
                    default: begin          // iastore, sastore, bastore, put
                        mem_we = 1'b1;
                        dsel_x = !last;
                    end
                endcase
                ibuf_x = (op == get);       // once, single data phase
                obuf_x = (op == put);
            end
        end
    end

    always_ff @(posedge ctl or negedge arst_n) begin
        if (!arst_n) begin
            addr_r <= '0;
            dsel   <= 2'd3;
            ibuf   <= asz'(tib_base);
            obuf   <= asz'(obuf_base);
        end else if (running) begin
            if (addr_x) addr_r <= addr_n;
            if (dsel_x) dsel   <= dsel_n;
            if (ibuf_x) ibuf   <= ibuf + 1'b1;
            if (obuf_x) obuf   <= obuf + 1'b1;
        end
    end

endmodule

// ==== tb.f ====
src/ls_types_pkg.sv
src/ls_map_pkg.sv
src/ls_sequencer.sv
src/ls_phase_counter.sv
src/ls_unit.sv
src/byte_ram.sv
src/ls_top.sv
test/tb_clock.sv
test/ls_props.sv
test/tb_top.sv

// ==== test/ls_props.sv ====
/* control checks on the load/store block
   done shape, done against busy, writes only inside a command */
`timescale 1ns/1ps

module ls_props import ls_types_pkg::*; (
    input logic               ctl,
    input logic               arst_n,
    input logic               busy,
    input logic               done,
    input logic               mem_we,
    input logic               running,
    input ls_op_t             cur_op,
    input logic [phase_w-1:0] phase
);

    done_single: assert property (@(posedge ctl) disable iff (!arst_n)
        done |=> !done)
        else $error("done high on two cycles in a row");

    done_not_busy: assert property (@(posedge ctl) disable iff (!arst_n)
        !(done && busy))
        else $error("done and busy high together");

    we_in_cmd: assert property (@(posedge ctl) disable iff (!arst_n)
        mem_we |-> busy)
        else $error("memory write outside a command");

    // phase never runs past the last byte of the command
    phase_bound: assert property (@(posedge ctl) disable iff (!arst_n)
        running |-> (phase <= op_last_phase(cur_op)))
        else $error("phase beyond last phase of command");

endmodule

bind ls_top ls_props u_props (
    .ctl     (ctl),
    .arst_n  (arst_n),
    .busy    (busy),
    .done    (done),
    .mem_we  (mem_we),
    .running (running),
    .cur_op  (cur_op),
    .phase   (phase)
);

// ==== test/tb_clock.sv ====
/* testbench clock and reset
   10 ns clock, reset held low for the first 4 cycles */
`timescale 1ns/1ps

module tb_clock (
    output logic ctl,
    output logic arst_n
);

    initial begin
        ctl = 1'b0;
        forever #5 ctl = ~ctl;              // 10 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge ctl);
        @(negedge ctl);                     // release away from the rising edge
        arst_n = 1'b1;
    end

endmodule

// ==== test/tb_top.sv ====
/* testbench for the load/store block
   random commands against a byte-array model, buffers and done timing */
`timescale 1ns/1ps

module tb_top import ls_types_pkg::*, ls_map_pkg::*;;

    logic           ctl;
    logic           arst_n;
    logic           start;
    ls_op_t         op;
    logic [dsz-1:0] tos_in;
    logic [dsz-1:0] nos_in;
    logic           busy;
    logic           done;
    logic [dsz-1:0] tos_out;

    logic [7:0]     model_mem [1 << ram_aw];  // mirror of the byte RAM
    logic [asz-1:0] model_ibuf;               // get pointer copy
    logic [asz-1:0] model_obuf;               // put pointer copy
    int             seed;

    tb_clock u_clk (
        .ctl    (ctl),
        .arst_n (arst_n)
    );

    ls_top UUT (
        .ctl     (ctl),
        .arst_n  (arst_n),
        .start   (start),
        .op      (op),
        .tos_in  (tos_in),
        .nos_in  (nos_in),
        .busy    (busy),
        .done    (done),
        .tos_out (tos_out)
    );

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // bytes moved by each command
    function automatic int op_bytes(ls_op_t c_op);
        case (c_op)
            iaload, iastore: return 4;
            saload, sastore: return 2;
            default:         return 1;
        endcase
    endfunction

    // big-endian assembly, zero-extended
    function automatic logic [31:0] model_load(ls_op_t c_op, logic [15:0] a);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < op_bytes(c_op); i++) begin
            v = {v[23:0], model_mem[12'(a + 16'(i))]};
        end
        return v;
    endfunction

    task automatic model_store(input ls_op_t c_op, input logic [15:0] a, input logic [31:0] d);
        int n;
        n = op_bytes(c_op);
        for (int i = 0; i < n; i++) begin
            model_mem[12'(a + 16'(i))] = d[8*(n-1-i) +: 8]; // msb first
        end
    endtask

    task automatic fail_now();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at time %0t: %s got %h expected %h", $time, what, got, exp);
            fail_now();
        end
    endtask

    // one command, entered and left at a falling edge
    task automatic run_cmd(input ls_op_t c_op, input logic [31:0] c_tos,
                           input logic [31:0] c_nos, input logic [31:0] exp_tos);
        int          edges;
        logic [31:0] junk;
        junk   = rand_word();
        start  = 1'b1;
        op     = c_op;
        tos_in = c_tos;
        nos_in = c_nos;
        @(posedge ctl);
        edges = 1;
        @(negedge ctl);
        check_eq(32'(busy), 32'd1, "busy after start");
        start  = junk[31];                  // stray start while busy, half the time
        op     = ls_op_t'(c_op + 3'd1);     // different command
        tos_in = ~c_tos;
        nos_in = ~c_nos ^ junk;
        while (done !== 1'b1 && edges < 16) begin
            @(posedge ctl);
            edges++;
            @(negedge ctl);
            start = 1'b0;
        end
        if (done !== 1'b1) begin
            $display("timeout: done never came for %s after %0d cycles", c_op.name(), edges);
            fail_now();
        end
        check_eq(edges, op_bytes(c_op) + 2, {c_op.name(), " done latency"});
        check_eq(32'(busy), 32'd0, "busy together with done");
        check_eq(tos_out, exp_tos, {c_op.name(), " tos_out"});
        @(posedge ctl);
        @(negedge ctl);
        check_eq(32'(done), 32'd0, "done longer than one cycle");
    endtask

    task automatic do_load(input ls_op_t c_op, input logic [15:0] a);
        run_cmd(c_op, {16'h0, a}, rand_word(), model_load(c_op, a));
    endtask

    task automatic do_store(input ls_op_t c_op, input logic [15:0] a, input logic [31:0] d);
        model_store(c_op, a, d);
        run_cmd(c_op, d, {16'h0, a}, d);    // tos keeps the data
    endtask

    task automatic do_get();
        logic [31:0] exp;
        exp        = {24'h0, model_mem[model_ibuf[ram_aw-1:0]]};
        model_ibuf = model_ibuf + 16'd1;
        run_cmd(get, rand_word(), rand_word(), exp);
    endtask

    task automatic do_put(input logic [31:0] d);
        model_mem[model_obuf[ram_aw-1:0]] = d[7:0];
        model_obuf = model_obuf + 16'd1;
        run_cmd(put, d, rand_word(), d);
    endtask

    initial begin
        logic [31:0] r;
        logic [15:0] a;
        logic [15:0] last_a;
        ls_op_t      c;
        int          cnt;
        seed       = 32'hc1aa_a699;
        start      = 1'b0;
        op         = iaload;
        tos_in     = '0;
        nos_in     = '0;
        model_ibuf = 16'(tib_base);
        model_obuf = 16'(obuf_base);
        last_a     = 16'h0;
        for (int i = 0; i < (1 << ram_aw); i++) begin
            model_mem[i] = 8'h00;           // RAM starts cleared
        end

        cnt = 0;
        while (arst_n !== 1'b1 && cnt < 20) begin
            @(negedge ctl);
            cnt++;
        end
        if (arst_n !== 1'b1) begin
            $display("reset was never released");
            fail_now();
        end
        @(negedge ctl);
        check_eq(32'(busy), 32'd0, "busy after reset");
        check_eq(32'(done), 32'd0, "done after reset");

        // mixed widths below the buffers, often reusing the last address
        for (int i = 0; i < 300; i++) begin
            r = rand_word();
            c = ls_op_t'(3'(r[7:0] % 8'd6));
            if (r[8]) a = last_a;
            else a = 16'(rand_word() % 32'd3068);
            last_a = a;
            if (c == iaload || c == saload || c == baload) begin
                do_load(c, a);
            end else begin
                do_store(c, a, rand_word());
            end
        end

        // input buffer filled by bastore, drained by get
        for (int i = 0; i < 8; i++) begin
            do_store(bastore, 16'(tib_base) + 16'(i), rand_word());
        end
        for (int i = 0; i < 8; i++) begin
            do_get();
        end

        // output buffer written by put, read back with baload
        for (int i = 0; i < 8; i++) begin
            do_put(rand_word());
        end
        for (int i = 0; i < 8; i++) begin
            do_load(baload, 16'(obuf_base) + 16'(i));
        end

        // whole RAM against the model, catches stray writes
        for (int i = 0; i < (1 << ram_aw); i += 4) begin
            do_load(iaload, 16'(i));
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
